// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

  // machine word width for addresses and data alike
  localparam int XLEN = 32;

  // fixed-size instructions only without compressed encodings
  localparam int INST_W     = 32;
  localparam int INST_BYTES = 4;

  // low pc bits that are always zero for an aligned instruction
  localparam int OFF_BITS = $clog2(INST_BYTES);

  typedef logic [XLEN-1:0]   pc_t;    // instruction address
  typedef logic [INST_W-1:0] inst_t;  // raw instruction word

endpackage

// ==== verilog/fetch_ifs.sv ====
`timescale 1ns/1ps

// fetch request from the pc generator to the memory side
interface fetch_req_if;
  import fetch_pkg::*;

  pc_t  pc;     // address offered for fetch
  logic valid;
  logic ready;
  logic flush;  // one-cycle pulse on trap or branch redirect

  modport gen (
    output pc,
    output valid,
    output flush,
    input  ready
  );

  modport fetch (
    input  pc,
    input  valid,
    input  flush,
    output ready
  );

endinterface

// lookup and training path between pc generator and btb
interface btb_if #(
  parameter int BTB_ENTRIES = 16
);
  import fetch_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = XLEN - IDX_W - OFF_BITS;

  pc_t  lookup_pc;
  logic hit;
  pc_t  target;
  logic upd_valid;   // resolved taken branch
  pc_t  upd_pc;      // branch source
  pc_t  upd_target;

  // entry index from the bits just above the instruction offset
  function automatic logic [IDX_W-1:0] index_of(input pc_t pc);
    return pc[OFF_BITS +: IDX_W];
  endfunction

  // remaining upper bits
  function automatic logic [TAG_W-1:0] tag_of(input pc_t pc);
    return pc[XLEN-1 -: TAG_W];
  endfunction

  modport gen (
    output lookup_pc,
    output upd_valid,
    output upd_pc,
    output upd_target,
    input  hit,
    input  target
  );

  // table side owned by the btb
  modport tbl (
    input  lookup_pc,
    input  upd_valid,
    input  upd_pc,
    input  upd_target,
    output hit,
    output target,
    import index_of,
    import tag_of
  );

endinterface

// ==== verilog/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen #(
  parameter fetch_pkg::pc_t RESET_ADDR = '0
) (
  input  logic           clk,
  input  logic           rst_i,
  input  fetch_pkg::pc_t clint_pc_i,         // trap target
  input  logic           clint_pc_valid_i,
  input  fetch_pkg::pc_t branch_src_pc_i,    // pc of the resolved branch
  input  fetch_pkg::pc_t branch_pc_i,        // its taken target
  input  logic           branch_pc_valid_i,
  fetch_req_if.gen       req,
  btb_if.gen             bp
);
  import fetch_pkg::*;

  pc_t  pc_q;
  pc_t  pc_d;
  pc_t  pc_seq;
  logic valid_q;
  logic redirect;
  logic fire;

  assign redirect = clint_pc_valid_i | branch_pc_valid_i;
  assign fire     = req.valid & req.ready;
  assign pc_seq   = pc_q + pc_t'(INST_BYTES);

  // trap beats branch beats btb prediction beats pc plus 4
  always_comb begin
    if (clint_pc_valid_i) begin
      pc_d = clint_pc_i;
    end else if (branch_pc_valid_i) begin
      pc_d = branch_pc_i;
    end else if (fire) begin
      pc_d = bp.hit ? bp.target : pc_seq;
    end else begin
      pc_d = pc_q;  // stall
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q    <= RESET_ADDR;
      valid_q <= 1'b0;
    end else begin
      pc_q    <= pc_d;
      valid_q <= 1'b1;  // always requesting once out of reset
    end
  end

  assign req.pc    = pc_q;
  assign req.valid = valid_q;
  assign req.flush = redirect;

  // predict on the pc being offered
  assign bp.lookup_pc = pc_q;

  // train on every resolved taken branch
  assign bp.upd_valid  = branch_pc_valid_i;
  assign bp.upd_pc     = branch_src_pc_i;
  assign bp.upd_target = branch_pc_i;

endmodule

// ==== verilog/btb.sv ====
`timescale 1ns/1ps

module btb #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic clk,
  input  logic rst_i,
  btb_if.tbl   bp
);
  import fetch_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = XLEN - IDX_W - OFF_BITS;

  logic [BTB_ENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]       tag_q    [BTB_ENTRIES];
  pc_t                    target_q [BTB_ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;

  assign rd_idx = bp.index_of(bp.lookup_pc);
  assign rd_tag = bp.tag_of(bp.lookup_pc);
  assign wr_idx = bp.index_of(bp.upd_pc);

  // same-cycle lookup
  assign bp.hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign bp.target = target_q[rd_idx];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (bp.upd_valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // a new branch simply evicts whatever sat at its index
  always_ff @(posedge clk) begin
    if (bp.upd_valid) begin
      tag_q[wr_idx]    <= bp.tag_of(bp.upd_pc);
      target_q[wr_idx] <= bp.upd_target;
    end
  end

endmodule

// ==== verilog/imem_apb_fetch.sv ====
`timescale 1ns/1ps

module imem_apb_fetch (
  input  logic             clk,
  input  logic             rst_i,
  fetch_req_if.fetch       req,
  // apb read master
  output fetch_pkg::pc_t   paddr_o,
  output logic             psel_o,
  output logic             penable_o,
  input  fetch_pkg::inst_t prdata_i,
  input  logic             pready_i,
  input  logic             pslverr_i,
  // toward decode
  output logic             inst_valid_o,
  output fetch_pkg::pc_t   inst_pc_o,
  output fetch_pkg::inst_t inst_o,
  output logic             inst_fault_o,
  input  logic             inst_ready_i
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_e;

  apb_state_e state_q;
  pc_t        addr_q;
  logic       stale_q;  // bus result belongs to a flushed path

  logic  out_valid_q;
  pc_t   out_pc_q;
  inst_t out_inst_q;
  logic  out_fault_q;

  logic fire;
  logic done;

  // no new request while flushing since the offered pc is the old path
  assign req.ready = (state_q == IDLE)
                   & (~out_valid_q | inst_ready_i)
                   & ~req.flush;
  assign fire = req.valid & req.ready;

  // completed read that is still wanted
  assign done = (state_q == ACCESS) & pready_i & ~stale_q & ~req.flush;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= IDLE;
      stale_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (fire) begin
            state_q <= SETUP;
          end
        end
        SETUP: begin
          state_q <= ACCESS;
        end
        ACCESS: begin
          if (pready_i) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase

      if (fire) begin
        stale_q <= 1'b0;
      end else if (req.flush && state_q != IDLE) begin
        stale_q <= 1'b1;  // cannot abort so let it finish and drop it
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      addr_q <= req.pc;  // held through setup and access
    end
  end

  // output register
  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_valid_q <= 1'b0;
    end else if (req.flush) begin
      out_valid_q <= 1'b0;
    end else if (done) begin
      out_valid_q <= 1'b1;
    end else if (inst_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      out_pc_q    <= addr_q;
      out_inst_q  <= prdata_i;
      out_fault_q <= pslverr_i;  // bus error becomes fetch fault
    end
  end

  assign paddr_o   = addr_q;
  assign psel_o    = (state_q != IDLE);
  assign penable_o = (state_q == ACCESS);

  assign inst_valid_o = out_valid_q;
  assign inst_pc_o    = out_pc_q;
  assign inst_o       = out_inst_q;
  assign inst_fault_o = out_fault_q;

endmodule

// ==== verilog/rv_fetch_top.sv ====
`timescale 1ns/1ps

module rv_fetch_top #(
  parameter fetch_pkg::pc_t RESET_ADDR  = 32'h8000_0000,
  parameter int             BTB_ENTRIES = 16
) (
  input  logic             clk,
  input  logic             rst_i,
  // redirects
  input  fetch_pkg::pc_t   clint_pc_i,
  input  logic             clint_pc_valid_i,
  input  fetch_pkg::pc_t   branch_src_pc_i,
  input  fetch_pkg::pc_t   branch_pc_i,
  input  logic             branch_pc_valid_i,
  // instruction memory, apb
  output fetch_pkg::pc_t   paddr_o,
  output logic             psel_o,
  output logic             penable_o,
  input  fetch_pkg::inst_t prdata_i,
  input  logic             pready_i,
  input  logic             pslverr_i,
  // decode
  output logic             inst_valid_o,
  output fetch_pkg::pc_t   inst_pc_o,
  output fetch_pkg::inst_t inst_o,
  output logic             inst_fault_o,
  input  logic             inst_ready_i
);
  import fetch_pkg::*;

  fetch_req_if req_if ();
  btb_if #(.BTB_ENTRIES(BTB_ENTRIES)) bp_if ();

  pc_gen #(
    .RESET_ADDR (RESET_ADDR)
  ) u_pc_gen (
    .clk               (clk),
    .rst_i             (rst_i),
    .clint_pc_i        (clint_pc_i),
    .clint_pc_valid_i  (clint_pc_valid_i),
    .branch_src_pc_i   (branch_src_pc_i),
    .branch_pc_i       (branch_pc_i),
    .branch_pc_valid_i (branch_pc_valid_i),
    .req               (req_if.gen),
    .bp                (bp_if.gen)
  );

  btb #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) u_btb (
    .clk   (clk),
    .rst_i (rst_i),
    .bp    (bp_if.tbl)
  );

  imem_apb_fetch u_imem_apb_fetch (
    .clk          (clk),
    .rst_i        (rst_i),
    .req          (req_if.fetch),
    .paddr_o      (paddr_o),
    .psel_o       (psel_o),
    .penable_o    (penable_o),
    .prdata_i     (prdata_i),
    .pready_i     (pready_i),
    .pslverr_i    (pslverr_i),
    .inst_valid_o (inst_valid_o),
    .inst_pc_o    (inst_pc_o),
    .inst_o       (inst_o),
    .inst_fault_o (inst_fault_o),
    .inst_ready_i (inst_ready_i)
  );

endmodule

// ==== verif/tb_rv_fetch.sv ====
`timescale 1ns/1ps

module tb_rv_fetch;
  import fetch_pkg::*;

  localparam pc_t RESET_ADDR  = 32'h0000_1000;
  localparam pc_t MEM_LIMIT   = 32'h0000_2000;  // bus error at and above
  localparam int  BTB_N       = 16;
  localparam int  IDX_W       = $clog2(BTB_N);
  localparam int  PLANNED     = 150;            // deliveries over all phases
  localparam int  WATCHDOG_NS = PLANNED * 12 * 10 * 2;

  logic  clk, rst_i;
  pc_t   clint_pc_i, branch_src_pc_i, branch_pc_i;
  logic  clint_pc_valid_i, branch_pc_valid_i;
  pc_t   paddr_o;
  logic  psel_o, penable_o, pready_i, pslverr_i;
  inst_t prdata_i;
  logic  inst_valid_o, inst_fault_o, inst_ready_i;
  pc_t   inst_pc_o;
  inst_t inst_o;

  pc_t  exp_pc;
  int   n_done;
  int   wait_cnt;
  logic ref_valid [BTB_N];
  pc_t  ref_src   [BTB_N];
  pc_t  ref_tgt   [BTB_N];

  logic apb_hold;  // transfer still open so the bus must stay in access
  logic apb_end;   // last cycle completed a transfer
  pc_t  apb_addr;

  rv_fetch_top #(.RESET_ADDR(RESET_ADDR), .BTB_ENTRIES(BTB_N)) uut (
    .clk(clk), .rst_i(rst_i),
    .clint_pc_i(clint_pc_i), .clint_pc_valid_i(clint_pc_valid_i),
    .branch_src_pc_i(branch_src_pc_i), .branch_pc_i(branch_pc_i),
    .branch_pc_valid_i(branch_pc_valid_i),
    .paddr_o(paddr_o), .psel_o(psel_o), .penable_o(penable_o),
    .prdata_i(prdata_i), .pready_i(pready_i), .pslverr_i(pslverr_i),
    .inst_valid_o(inst_valid_o), .inst_pc_o(inst_pc_o), .inst_o(inst_o),
    .inst_fault_o(inst_fault_o), .inst_ready_i(inst_ready_i)
  );

  always #5 clk = ~clk;

  // memory content as a rotate and xor of the full address
  function automatic inst_t mem_word(input pc_t a);
    return inst_t'({a[7:0], a[31:8]} ^ 32'hC3A5_5A3C);
  endfunction

  function automatic logic [IDX_W-1:0] ref_idx(input pc_t a);
    return a[OFF_BITS +: IDX_W];
  endfunction

  function automatic logic ref_hit(input pc_t a);
    return ref_valid[ref_idx(a)] &&
           (ref_src[ref_idx(a)][XLEN-1:OFF_BITS] == a[XLEN-1:OFF_BITS]);
  endfunction

  // next expected delivery with trap over branch over prediction over pc + 4
  function automatic pc_t ref_next(input pc_t cur, input logic trap, input pc_t trap_pc,
                                   input logic br, input pc_t br_pc, input logic adv);
    if (trap) return trap_pc;
    if (br) return br_pc;
    if (!adv) return cur;
    return ref_hit(cur) ? ref_tgt[ref_idx(cur)] : cur + 32'd4;
  endfunction

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_fault(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic compare_ctrl(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // apb slave with 0 to 3 wait states per read
  always @(posedge clk) begin
    #1;
    prdata_i  = mem_word(paddr_o);
    pslverr_i = (paddr_o >= MEM_LIMIT);
    if (psel_o && !penable_o) begin
      wait_cnt = int'($urandom % 4);
      pready_i = 1'b0;
    end else if (psel_o && penable_o && wait_cnt == 0) begin
      pready_i = 1'b1;
    end else begin
      if (psel_o) wait_cnt = wait_cnt - 1;
      pready_i = 1'b0;
    end
  end

  // apb master sequencing of setup and access around a steady address
  always @(posedge clk) begin
    if (rst_i) begin
      apb_hold = 1'b0;
      apb_end  = 1'b0;
    end else begin
      if (penable_o) begin
        compare_ctrl("psel_o", psel_o, 1'b1);
      end
      if (apb_hold) begin
        compare_ctrl("penable_o", penable_o, 1'b1);
        check_pc("paddr_o", paddr_o, apb_addr);
      end
      if (apb_end) begin
        compare_ctrl("penable_o", penable_o, 1'b0);
      end
      apb_hold = psel_o && !(penable_o && pready_i);
      apb_end  = penable_o && pready_i;
      apb_addr = paddr_o;
    end
  end

  // decode back-pressure
  always @(posedge clk) begin
    #1;
    inst_ready_i = ($urandom % 4) != 0;
  end

  // compare every decode handshake against the model
  always @(posedge clk) begin
    logic hs;
    hs = inst_valid_o && inst_ready_i;
    if (rst_i) begin
      exp_pc = RESET_ADDR;
      for (int i = 0; i < BTB_N; i++) ref_valid[i] = 1'b0;
    end else begin
      if (hs) begin
        check_pc("inst_pc_o", inst_pc_o, exp_pc);
        check_inst("inst_o", inst_o, mem_word(exp_pc));
        check_fault("inst_fault_o", inst_fault_o, exp_pc >= MEM_LIMIT);
        n_done = n_done + 1;
      end
      exp_pc = ref_next(exp_pc, clint_pc_valid_i, clint_pc_i,
                        branch_pc_valid_i, branch_pc_i, hs);
      if (branch_pc_valid_i) begin  // train after the lookup above
        ref_valid[ref_idx(branch_src_pc_i)] = 1'b1;
        ref_src[ref_idx(branch_src_pc_i)]   = branch_src_pc_i;
        ref_tgt[ref_idx(branch_src_pc_i)]   = branch_pc_i;
      end
    end
  end

  task automatic wait_deliveries(input int n);
    int target;
    target = n_done + n;
    wait (n_done >= target);
  endtask

  // one-cycle redirect pulse
  task automatic apply_redirect(input logic trap, input pc_t trap_pc,
                                input logic br, input pc_t src, input pc_t tgt);
    @(posedge clk);
    #1;
    clint_pc_valid_i  = trap;
    clint_pc_i        = trap_pc;
    branch_pc_valid_i = br;
    branch_src_pc_i   = src;
    branch_pc_i       = tgt;
    @(posedge clk);
    #1;
    clint_pc_valid_i  = 1'b0;
    branch_pc_valid_i = 1'b0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, decode stopped receiving instructions");
    $display("Test FAILED");
    $fatal(1);
  end

  initial begin
    void'($urandom(64));
    clk = 1'b0;
    rst_i = 1'b1;
    clint_pc_i = '0;
    clint_pc_valid_i = 1'b0;
    branch_src_pc_i = '0;
    branch_pc_i = '0;
    branch_pc_valid_i = 1'b0;
    prdata_i = '0;
    pready_i = 1'b0;
    pslverr_i = 1'b0;
    inst_ready_i = 1'b0;
    n_done = 0;
    wait_cnt = 0;
    repeat (5) @(posedge clk);
    #1 rst_i = 1'b0;

    // bus and decode side idle straight out of reset
    compare_ctrl("psel_o", psel_o, 1'b0);
    compare_ctrl("penable_o", penable_o, 1'b0);
    compare_ctrl("inst_valid_o", inst_valid_o, 1'b0);

    wait_deliveries(30);                                     // sequential run
    apply_redirect(1'b1, 32'h1400, 1'b0, '0, '0);            // trap
    wait_deliveries(10);
    apply_redirect(1'b0, '0, 1'b1, 32'h1500, 32'h1200);      // branch
    wait_deliveries(10);
    apply_redirect(1'b1, 32'h1600, 1'b1, 32'h1700, 32'h1300); // trap wins
    wait_deliveries(10);
    apply_redirect(1'b0, '0, 1'b1, 32'h10c0, 32'h1080);      // loop via btb
    wait_deliveries(40);
    apply_redirect(1'b0, '0, 1'b1, 32'h10c0, 32'h10a0);      // entry replaced
    wait_deliveries(30);
    apply_redirect(1'b1, 32'h1fe0, 1'b0, '0, '0);            // run past limit
    wait_deliveries(20);

    $display("Test OK");
    $finish;
  end

endmodule

// ==== rv_fetch.f ====
verilog/fetch_pkg.sv
verilog/fetch_ifs.sv
verilog/pc_gen.sv
verilog/btb.sv
verilog/imem_apb_fetch.sv
verilog/rv_fetch_top.sv
verif/tb_rv_fetch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rv_fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 \
    --top-module tb_rv_fetch \
    -f rv_fetch.f \
    -o tb_rv_fetch; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_rv_fetch; then
  echo "simulation reported failure"
  exit 1
fi

exit 0
